// ==== exu.f ====
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_decode.sv
verilog/exu_regfile.sv
verilog/exu_alu.sv
verilog/exu_csr.sv
verilog/exu_commit.sv
verilog/exu_top.sv
verif/exu_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the exu execute unit

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f exu.f --top-module exu_top

sim:
	verilator --binary --assert -Wno-fatal -j 0 -f exu.f --top-module exu_tb -o exu_sim
	./obj_dir/exu_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/exu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the execute unit
// Directed and random instruction streams, checked against a reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 5;

  logic                    clk = 1'b0;
  logic                    i_reset;
  logic                    i_valid;
  logic                    o_ready;
  logic [`EXU_INSTR_W-1:0] i_ir;
  exu_pkg::word_t          i_pc;
  logic                    o_wbck_valid;
  exu_pkg::rfidx_t         o_wbck_rdidx;
  exu_pkg::word_t          o_wbck_wdat;
  logic                    o_commit_trap;

  integer seed      = 46214;
  int     err_wbck  = 0;
  int     err_trap  = 0;
  int     err_other = 0;
  int     acc_cnt   = 0;
  int     n_instr   = 0;
  logic   armed     = 1'b0;

  logic [`EXU_INSTR_W-1:0] prog_ir [$];
  string                   prog_tag [$];

  // Reference state
  exu_pkg::word_t ref_rf [0:31];
  exu_pkg::word_t ref_mscratch;
  exu_pkg::word_t ref_mepc;
  exu_pkg::word_t ref_mcause;
  exu_pkg::word_t ref_minstret;

  // Expected outputs for the cycle after an edge
  logic            exp_valid = 1'b0;
  logic            exp_trap  = 1'b0;
  exu_pkg::rfidx_t exp_rd;
  exu_pkg::word_t  exp_dat;
  string           exp_name  = "reset";

  exu_top dut (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_ir          (i_ir),
    .i_pc          (i_pc),
    .o_wbck_valid  (o_wbck_valid),
    .o_wbck_rdidx  (o_wbck_rdidx),
    .o_wbck_wdat   (o_wbck_wdat),
    .o_commit_trap (o_commit_trap)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoding and program build

  function automatic logic [31:0] make_rtype(input logic [6:0] f7, input int rs2,
                                             input int rs1, input logic [2:0] f3,
                                             input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `EXU_OPC_OP};
  endfunction

  function automatic logic [31:0] make_itype(input logic [11:0] imm, input int rs1,
                                             input logic [2:0] f3, input int rd,
                                             input logic [6:0] opc);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
  endfunction

  task automatic add_instr(input string tag, input logic [31:0] ir);
    prog_ir.push_back(ir);
    prog_tag.push_back(tag);
  endtask

  // mepc into x8, mcause into x9
  task automatic append_cause_reads();
    add_instr("read_mepc", make_itype(`EXU_CSR_MEPC, 0, `EXU_F3_CSRRS, 8, `EXU_OPC_SYSTEM));
    add_instr("read_mcause", make_itype(`EXU_CSR_MCAUSE, 0, `EXU_F3_CSRRS, 9, `EXU_OPC_SYSTEM));
  endtask

  // Registers x0..x7 only, so neighbours often depend on each other
  task automatic gen_random_alu(input int n);
    exu_pkg::word_t r;
    exu_pkg::word_t s;
    logic [2:0]     f3;
    logic [11:0]    imm;
    for (int k = 0; k < n; k++) begin
      r  = $random(seed);
      s  = $random(seed);
      f3 = r[11:9];
      if (r[13]) begin
        add_instr("random_reg", make_rtype((r[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                           r[8:6], r[5:3], f3, r[2:0]));
      end else begin
        imm = s[11:0];
        if (f3 == 3'd1) imm = {7'h00, s[4:0]};
        if (f3 == 3'd5) imm = {r[12] ? 7'h20 : 7'h00, s[4:0]};
        add_instr("random_imm", make_itype(imm, r[5:3], f3, r[2:0], `EXU_OPC_OPIMM));
      end
    end
  endtask

  task automatic build_program();
    add_instr("addi_load", make_itype(12'h123, 0, `EXU_F3_ADD, 1, `EXU_OPC_OPIMM));
    add_instr("addi_load", make_itype(12'hFFF, 0, `EXU_F3_ADD, 2, `EXU_OPC_OPIMM));
    add_instr("addi_load", make_itype(12'h800, 0, `EXU_F3_ADD, 3, `EXU_OPC_OPIMM));
    add_instr("addi_load", make_itype(12'h7FF, 0, `EXU_F3_ADD, 4, `EXU_OPC_OPIMM));
    add_instr("addi_load", make_itype(12'h055, 0, `EXU_F3_ADD, 5, `EXU_OPC_OPIMM));
    add_instr("addi_load", make_itype(12'hF0F, 0, `EXU_F3_ADD, 6, `EXU_OPC_OPIMM));
    add_instr("addi_load", make_itype(12'h001, 0, `EXU_F3_ADD, 7, `EXU_OPC_OPIMM));
    add_instr("alu_chain", make_rtype(7'h00, 2, 1, `EXU_F3_ADD, 1));
    add_instr("alu_chain", make_rtype(7'h20, 4, 1, `EXU_F3_ADD, 3));
    add_instr("alu_chain", make_rtype(7'h20, 7, 3, `EXU_F3_SR, 5));
    add_instr("alu_chain", make_rtype(7'h00, 4, 5, `EXU_F3_SLTU, 6));
    gen_random_alu(80);
    // x0 targets, then x0 as a source
    add_instr("x0_write", make_itype(12'h005, 1, `EXU_F3_ADD, 0, `EXU_OPC_OPIMM));
    add_instr("x0_write", make_rtype(7'h00, 3, 2, `EXU_F3_OR, 0));
    add_instr("x0_read", make_rtype(7'h00, 0, 0, `EXU_F3_ADD, 5));
    add_instr("x0_read", make_itype(12'h000, 0, `EXU_F3_XOR, 6, `EXU_OPC_OPIMM));
    // Traps
    add_instr("bad_opcode", make_itype(12'h000, 1, 3'd0, 2, 7'b0001011));
    append_cause_reads();
    add_instr("bad_srli", make_itype({7'h10, 5'd3}, 1, `EXU_F3_SR, 4, `EXU_OPC_OPIMM));
    append_cause_reads();
    add_instr("bad_csr", make_itype(12'h300, 0, `EXU_F3_CSRRS, 4, `EXU_OPC_SYSTEM));
    append_cause_reads();
    // mscratch swap, set and minstret
    add_instr("csr_swap", make_itype(`EXU_CSR_MSCRATCH, 1, `EXU_F3_CSRRW, 6, `EXU_OPC_SYSTEM));
    add_instr("csr_read", make_itype(`EXU_CSR_MSCRATCH, 0, `EXU_F3_CSRRS, 7, `EXU_OPC_SYSTEM));
    add_instr("csr_set", make_itype(`EXU_CSR_MSCRATCH, 2, `EXU_F3_CSRRS, 0, `EXU_OPC_SYSTEM));
    add_instr("csr_read", make_itype(`EXU_CSR_MSCRATCH, 0, `EXU_F3_CSRRS, 7, `EXU_OPC_SYSTEM));
    add_instr("csr_swap", make_itype(`EXU_CSR_MSCRATCH, 3, `EXU_F3_CSRRW, 12, `EXU_OPC_SYSTEM));
    add_instr("minstret", make_itype(`EXU_CSR_MINSTRET, 0, `EXU_F3_CSRRS, 8, `EXU_OPC_SYSTEM));
    add_instr("minstret", make_itype(`EXU_CSR_MINSTRET, 7, `EXU_F3_CSRRW, 9, `EXU_OPC_SYSTEM));
    add_instr("minstret", make_itype(`EXU_CSR_MINSTRET, 0, `EXU_F3_CSRRS, 10, `EXU_OPC_SYSTEM));
    gen_random_alu(20);
    add_instr("minstret", make_itype(`EXU_CSR_MINSTRET, 0, `EXU_F3_CSRRS, 11, `EXU_OPC_SYSTEM));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic exu_pkg::word_t alu_result(input logic [2:0] f3, input logic alt,
                                                input exu_pkg::word_t a,
                                                input exu_pkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? exu_pkg::word_t'($signed(a) >>> sh) : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Returns the expected writeback valid and updates the model state
  function automatic logic exu_ref_step(
    input  logic [`EXU_INSTR_W-1:0] ir,
    input  exu_pkg::word_t          pc,
    output exu_pkg::rfidx_t         rd,
    output exu_pkg::word_t          res,
    output logic                    trap
  );
    logic [6:0]     f7;
    logic [2:0]     f3;
    logic [11:0]    imm12;
    exu_pkg::word_t a;
    exu_pkg::word_t b;
    exu_pkg::word_t csr_new;
    logic           ilgl;
    logic           csr_wr;
    f7      = ir[31:25];
    f3      = ir[14:12];
    imm12   = ir[31:20];
    rd      = ir[11:7];
    a       = ref_rf[ir[19:15]];
    b       = ref_rf[ir[24:20]];
    res     = '0;
    ilgl    = 1'b0;
    csr_wr  = 1'b0;
    csr_new = '0;
    case (ir[6:0])
      `EXU_OPC_OP: begin
        ilgl = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        res  = alu_result(f3, f7[5], a, b);
      end
      `EXU_OPC_OPIMM: begin
        b = {{20{imm12[11]}}, imm12};
        if (f3 == 3'd1) ilgl = (f7 != 7'h00);
        if (f3 == 3'd5) ilgl = !(f7 == 7'h00 || f7 == 7'h20);
        res = alu_result(f3, f3 == 3'd5 && f7[5], a, b);  // No SUBI
      end
      `EXU_OPC_SYSTEM: begin
        ilgl = !(f3 == 3'd1 || f3 == 3'd2);
        case (imm12)
          `EXU_CSR_MSCRATCH: res = ref_mscratch;
          `EXU_CSR_MEPC:     res = ref_mepc;
          `EXU_CSR_MCAUSE:   res = ref_mcause;
          `EXU_CSR_MINSTRET: res = ref_minstret;
          default:           ilgl = 1'b1;
        endcase
        csr_new = (f3 == 3'd2) ? (res | a) : a;
        csr_wr  = !ilgl && (f3 == 3'd1 || a != '0);  // Set of no bits is a read
      end
      default: ilgl = 1'b1;
    endcase
    trap = ilgl;
    if (ilgl) begin
      ref_mepc   = pc;
      ref_mcause = `EXU_CAUSE_ILLEGAL;
      return 1'b0;
    end
    if (csr_wr && imm12 == `EXU_CSR_MSCRATCH) ref_mscratch = csr_new;
    if (csr_wr && imm12 == `EXU_CSR_MEPC) ref_mepc = csr_new;
    if (csr_wr && imm12 == `EXU_CSR_MCAUSE) ref_mcause = csr_new;
    if (csr_wr && imm12 == `EXU_CSR_MINSTRET) ref_minstret = csr_new;
    else ref_minstret = ref_minstret + 32'd1;
    if (rd != '0) ref_rf[rd] = res;
    return rd != '0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic check_wbck(input string name, input logic exp_v,
                            input exu_pkg::rfidx_t rd, input exu_pkg::word_t dat);
    if (o_wbck_valid !== exp_v) begin
      err_wbck++;
      $display("[FAIL] %s: wbck_valid expected %0b actual %0b", name, exp_v, o_wbck_valid);
    end else if (exp_v && (o_wbck_rdidx !== rd || o_wbck_wdat !== dat)) begin
      err_wbck++;
      $display("[FAIL] %s: writeback expected x%0d=0x%08h actual x%0d=0x%08h",
               name, rd, dat, o_wbck_rdidx, o_wbck_wdat);
    end
  endtask

  task automatic check_trap(input string name, input logic exp_t);
    if (o_commit_trap !== exp_t) begin
      err_trap++;
      $display("[FAIL] %s: commit_trap expected %0b actual %0b", name, exp_t, o_commit_trap);
    end
  endtask

  // Accepts seen at the edge set what the next cycle must show
  always @(posedge clk) begin
    if (i_valid && o_ready) begin
      exp_valid = exu_ref_step(i_ir, i_pc, exp_rd, exp_dat, exp_trap);
      exp_name  = $sformatf("%s #%0d", prog_tag[acc_cnt], acc_cnt);
      acc_cnt++;
    end else begin
      exp_valid = 1'b0;
      exp_trap  = 1'b0;
      exp_name  = "idle";
    end
    armed = 1'b1;
  end

  always @(negedge clk) begin
    if (armed) begin
      check_wbck(exp_name, exp_valid, exp_rd, exp_dat);
      check_trap(exp_name, exp_trap);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic present_instr(input int idx);
    if (idx < n_instr) begin
      i_valid <= (($random(seed) & 3) != 0);
      i_ir    <= prog_ir[idx];
      i_pc    <= 32'h100 + 32'(idx * 4);
    end else begin
      i_valid <= 1'b0;
    end
  endtask

  initial begin : main
    int idx;
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_ir    = '0;
    i_pc    = '0;
    for (int k = 0; k < 32; k++) ref_rf[k] = '0;
    ref_mscratch = '0;
    ref_mepc     = '0;
    ref_mcause   = '0;
    ref_minstret = '0;
    build_program();
    n_instr = prog_ir.size();

    @(posedge clk);
    @(negedge clk);
    if (o_ready !== 1'b0 || o_wbck_valid !== 1'b0 || o_commit_trap !== 1'b0) begin
      err_other++;
      $display("Ready, writeback valid or trap is not low during reset");
    end
    repeat (RESET_CYCLES - 1) @(posedge clk);
    i_reset <= 1'b0;

    idx = 0;
    present_instr(idx);
    while (idx < n_instr) begin
      @(posedge clk);
      if (i_valid && o_ready) idx++;
      present_instr(idx);
    end
    repeat (2) @(posedge clk);   // Last result checked at the negedge between

    $display("Summary: %0d instructions, %0d writeback errors, %0d trap errors, %0d other errors",
             acc_cnt, err_wbck, err_trap, err_other);
    if (err_wbck + err_trap + err_other == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Margin of 8 cycles per instruction on top of reset
  initial begin : watchdog
    int limit;
    wait (n_instr > 0);
    limit = (RESET_CYCLES + 8 * n_instr) * CLK_PERIOD;
    #(limit);
    $display("Timeout after %0d ns with %0d of %0d instructions accepted",
             limit, acc_cnt, n_instr);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/exu_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Execute unit top, single issue with one cycle to writeback or trap
// Fetch side presents i_valid with i_ir and i_pc, no back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_top (
  input  wire                          clk,
  input  wire                          i_reset,
  input  wire                          i_valid,
  output logic                         o_ready,
  input  wire  [`EXU_INSTR_W-1:0]      i_ir,
  input  wire  exu_pkg::word_t         i_pc,
  output logic                         o_wbck_valid,
  output exu_pkg::rfidx_t              o_wbck_rdidx,
  output exu_pkg::word_t               o_wbck_wdat,
  output logic                         o_commit_trap
);

  logic accept;

  assign o_ready = !i_reset;
  assign accept  = i_valid && o_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and register read
  exu_pkg::rfidx_t           dec_rs1idx;
  exu_pkg::rfidx_t           dec_rs2idx;
  exu_pkg::rfidx_t           dec_rdidx;
  logic                      dec_rdwen;
  exu_pkg::alu_op_e          dec_alu_op;
  logic                      dec_use_imm;
  exu_pkg::word_t            dec_imm;
  exu_pkg::csr_op_e          dec_csr_op;
  logic [`EXU_CSR_IDX_W-1:0] dec_csr_idx;
  logic                      dec_ilegl;
  exu_pkg::word_t            rf_rs1;
  exu_pkg::word_t            rf_rs2;
  logic                      rf_wen;
  exu_pkg::word_t            rf_wdat;

  exu_decode u_decode (
    .i_ir      (i_ir),
    .o_rs1idx  (dec_rs1idx),
    .o_rs2idx  (dec_rs2idx),
    .o_rdidx   (dec_rdidx),
    .o_rdwen   (dec_rdwen),
    .o_alu_op  (dec_alu_op),
    .o_use_imm (dec_use_imm),
    .o_imm     (dec_imm),
    .o_csr_op  (dec_csr_op),
    .o_csr_idx (dec_csr_idx),
    .o_ilegl   (dec_ilegl)
  );

  exu_regfile u_regfile (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_rs1idx (dec_rs1idx),
    .i_rs2idx (dec_rs2idx),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2),
    .i_wen    (rf_wen),
    .i_wdidx  (dec_rdidx),    // Same instruction, write lands at its accept
    .i_wdat   (rf_wdat)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute, CSR and commit
  exu_pkg::word_t alu_res;
  exu_pkg::word_t csr_rdat;
  logic           csr_ilgl;
  logic           cmt_ena;
  logic           cmt_trap;
  exu_pkg::word_t cmt_trap_pc;

  exu_alu u_alu (
    .i_op      (dec_alu_op),
    .i_rs1     (rf_rs1),
    .i_rs2     (rf_rs2),
    .i_use_imm (dec_use_imm),
    .i_imm     (dec_imm),
    .o_res     (alu_res)
  );

  exu_csr u_csr (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_csr_op   (dec_csr_op),
    .i_csr_idx  (dec_csr_idx),
    .i_wdat     (rf_rs1),
    .i_cmt_ena  (cmt_ena),
    .i_trap     (cmt_trap),
    .i_trap_pc  (cmt_trap_pc),
    .o_rdat     (csr_rdat),
    .o_csr_ilgl (csr_ilgl)
  );

  exu_commit u_commit (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_accept      (accept),
    .i_ilegl       (dec_ilegl),
    .i_csr_ilgl    (csr_ilgl),
    .i_is_csr      (dec_csr_op != exu_pkg::CSR_NONE),
    .i_rdwen       (dec_rdwen),
    .i_rdidx       (dec_rdidx),
    .i_pc          (i_pc),
    .i_alu_res     (alu_res),
    .i_csr_rdat    (csr_rdat),
    .o_cmt_ena     (cmt_ena),
    .o_trap        (cmt_trap),
    .o_trap_pc     (cmt_trap_pc),
    .o_rf_wen      (rf_wen),
    .o_rf_wdat     (rf_wdat),
    .o_wbck_valid  (o_wbck_valid),
    .o_wbck_rdidx  (o_wbck_rdidx),
    .o_wbck_wdat   (o_wbck_wdat),
    .o_commit_trap (o_commit_trap)
  );

endmodule

`default_nettype wire

// ==== verilog/exu_commit.sv ====
////////////////////////////////////////////////////////////////////////////
// Commit stage, decides trap or retire and picks the ALU or CSR result
// Strobes to csr and regfile are combinational, writeback is registered
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exu_commit (
  input  wire                   clk,
  input  wire                   i_reset,
  input  wire                   i_accept,
  input  wire                   i_ilegl,
  input  wire                   i_csr_ilgl,
  input  wire                   i_is_csr,
  input  wire                   i_rdwen,
  input  wire  exu_pkg::rfidx_t i_rdidx,
  input  wire  exu_pkg::word_t  i_pc,
  input  wire  exu_pkg::word_t  i_alu_res,
  input  wire  exu_pkg::word_t  i_csr_rdat,
  output logic                  o_cmt_ena,
  output logic                  o_trap,
  output exu_pkg::word_t        o_trap_pc,
  output logic                  o_rf_wen,
  output exu_pkg::word_t        o_rf_wdat,
  output logic                  o_wbck_valid,
  output exu_pkg::rfidx_t       o_wbck_rdidx,
  output exu_pkg::word_t        o_wbck_wdat,
  output logic                  o_commit_trap
);

  assign o_trap    = i_accept && (i_ilegl || i_csr_ilgl);
  assign o_cmt_ena = i_accept && !o_trap;
  assign o_trap_pc = i_pc;  // Becomes mepc

  // Regfile sees the write at the accepting edge
  assign o_rf_wen  = o_cmt_ena && i_rdwen && (i_rdidx != '0);
  assign o_rf_wdat = i_is_csr ? i_csr_rdat : i_alu_res;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_wbck_valid  <= 1'b0;
      o_commit_trap <= 1'b0;
    end else begin
      o_wbck_valid  <= o_rf_wen;
      o_commit_trap <= o_trap;
    end
  end

  always_ff @(posedge clk) begin
    if (o_rf_wen) begin
      o_wbck_rdidx <= i_rdidx;
      o_wbck_wdat  <= o_rf_wdat;
    end
  end

  a_wbck_trap_excl: assert property (@(posedge clk) disable iff (i_reset)
    !(o_wbck_valid && o_commit_trap));

endmodule

`default_nettype wire

// ==== verilog/exu_csr.sv ====
////////////////////////////////////////////////////////////////////////////
// Machine CSRs beside commit: mscratch, mepc, mcause and minstret
// Read is combinational, updates land on the commit or trap strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_csr (
  input  wire                            clk,
  input  wire                            i_reset,
  input  wire  exu_pkg::csr_op_e         i_csr_op,
  input  wire  [`EXU_CSR_IDX_W-1:0]      i_csr_idx,
  input  wire  exu_pkg::word_t           i_wdat,
  input  wire                            i_cmt_ena,
  input  wire                            i_trap,
  input  wire  exu_pkg::word_t           i_trap_pc,
  output exu_pkg::word_t                 o_rdat,
  output logic                           o_csr_ilgl
);

  exu_pkg::word_t mscratch_q;
  exu_pkg::word_t mepc_q;
  exu_pkg::word_t mcause_q;
  exu_pkg::word_t minstret_q;
  exu_pkg::word_t wr_val;
  logic           known;
  logic           wr_en;

  always_comb begin
    known  = 1'b1;
    o_rdat = '0;
    case (i_csr_idx)
      `EXU_CSR_MSCRATCH: o_rdat = mscratch_q;
      `EXU_CSR_MEPC:     o_rdat = mepc_q;
      `EXU_CSR_MCAUSE:   o_rdat = mcause_q;
      `EXU_CSR_MINSTRET: o_rdat = minstret_q;
      default:           known  = 1'b0;
    endcase
  end

  assign o_csr_ilgl = (i_csr_op != exu_pkg::CSR_NONE) && !known;

  // A set with no bits to set is a pure read
  assign wr_val = (i_csr_op == exu_pkg::CSR_SET) ? (o_rdat | i_wdat) : i_wdat;
  assign wr_en  = i_cmt_ena && ((i_csr_op == exu_pkg::CSR_WRITE) ||
                                (i_csr_op == exu_pkg::CSR_SET && |i_wdat));

  always_ff @(posedge clk) begin
    if (i_reset) begin
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      minstret_q <= '0;
    end else begin
      if (wr_en && i_csr_idx == `EXU_CSR_MSCRATCH) mscratch_q <= wr_val;

      if (i_trap) begin                 // Exception recording
        mepc_q   <= i_trap_pc;
        mcause_q <= `EXU_CAUSE_ILLEGAL;
      end else begin
        if (wr_en && i_csr_idx == `EXU_CSR_MEPC)   mepc_q   <= wr_val;
        if (wr_en && i_csr_idx == `EXU_CSR_MCAUSE) mcause_q <= wr_val;
      end

      // Explicit write wins over the retire count
      if (wr_en && i_csr_idx == `EXU_CSR_MINSTRET) minstret_q <= wr_val;
      else if (i_cmt_ena) minstret_q <= minstret_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exu_alu.sv ====
////////////////////////////////////////////////////////////////////////////
// Combinational integer ALU
// Second operand is rs2 or the decoded immediate
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_alu (
  input  wire  exu_pkg::alu_op_e i_op,
  input  wire  exu_pkg::word_t   i_rs1,
  input  wire  exu_pkg::word_t   i_rs2,
  input  wire                    i_use_imm,
  input  wire  exu_pkg::word_t   i_imm,
  output exu_pkg::word_t         o_res
);

  localparam int SHW = $clog2(`EXU_XLEN);

  exu_pkg::word_t op2;
  logic [SHW-1:0] shamt;

  assign op2   = i_use_imm ? i_imm : i_rs2;
  assign shamt = op2[SHW-1:0];   // Upper bits ignored

  always_comb begin
    o_res = '0;
    case (i_op)
      exu_pkg::ALU_ADD:  o_res = i_rs1 + op2;
      exu_pkg::ALU_SUB:  o_res = i_rs1 - op2;
      exu_pkg::ALU_SLL:  o_res = i_rs1 << shamt;
      exu_pkg::ALU_SLT:  o_res[0] = $signed(i_rs1) < $signed(op2);
      exu_pkg::ALU_SLTU: o_res[0] = i_rs1 < op2;
      exu_pkg::ALU_XOR:  o_res = i_rs1 ^ op2;
      exu_pkg::ALU_SRL:  o_res = i_rs1 >> shamt;
      exu_pkg::ALU_SRA:  o_res = exu_pkg::word_t'($signed(i_rs1) >>> shamt);
      exu_pkg::ALU_OR:   o_res = i_rs1 | op2;
      exu_pkg::ALU_AND:  o_res = i_rs1 & op2;
      default:           o_res = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/exu_regfile.sv ====
////////////////////////////////////////////////////////////////////////////
// Integer register file, x1 to x31 in flops, x0 reads as zero
// Two combinational read ports and one write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_regfile (
  input  wire                   clk,
  input  wire                   i_reset,
  input  wire  exu_pkg::rfidx_t i_rs1idx,
  input  wire  exu_pkg::rfidx_t i_rs2idx,
  output exu_pkg::word_t        o_rs1,
  output exu_pkg::word_t        o_rs2,
  input  wire                   i_wen,
  input  wire  exu_pkg::rfidx_t i_wdidx,
  input  wire  exu_pkg::word_t  i_wdat
);

  localparam int NREGS = 1 << `EXU_RFIDX_W;

  exu_pkg::word_t rf_q [1:NREGS-1];

  always_ff @(posedge clk) begin
    for (int k = 1; k < NREGS; k++) begin
      if (i_reset) rf_q[k] <= '0;
      else if (i_wen && i_wdidx == exu_pkg::rfidx_t'(k)) rf_q[k] <= i_wdat;
    end
  end

  // Read muxes, no entry matches index 0
  always_comb begin
    o_rs1 = '0;
    o_rs2 = '0;
    for (int k = 1; k < NREGS; k++) begin
      if (i_rs1idx == exu_pkg::rfidx_t'(k)) o_rs1 = rf_q[k];
      if (i_rs2idx == exu_pkg::rfidx_t'(k)) o_rs2 = rf_q[k];
    end
  end

  // Commit must filter rd of zero before it reaches the write port
  a_no_x0_write: assert property (@(posedge clk) disable iff (i_reset)
    i_wen |-> (i_wdidx != '0));

endmodule

`default_nettype wire

// ==== verilog/exu_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction decode for OP, OP-IMM and the CSR subset of SYSTEM
// Purely combinational, drives regfile indices and ALU/CSR/commit controls
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_decode (
  input  wire  logic [`EXU_INSTR_W-1:0] i_ir,
  output exu_pkg::rfidx_t               o_rs1idx,
  output exu_pkg::rfidx_t               o_rs2idx,
  output exu_pkg::rfidx_t               o_rdidx,
  output logic                          o_rdwen,
  output exu_pkg::alu_op_e              o_alu_op,
  output logic                          o_use_imm,
  output exu_pkg::word_t                o_imm,
  output exu_pkg::csr_op_e              o_csr_op,
  output logic [`EXU_CSR_IDX_W-1:0]     o_csr_idx,
  output logic                          o_ilegl
);

  exu_pkg::instr_u  ir;
  exu_pkg::alu_op_e base_op;   // Op selected by funct3 alone
  logic             hi_base;   // Upper seven bits all zero
  logic             hi_alt;    // Upper seven bits select SUB/SRA

  assign ir      = exu_pkg::instr_u'(i_ir);
  assign hi_base = (ir.r.funct7 == `EXU_F7_BASE);
  assign hi_alt  = (ir.r.funct7 == `EXU_F7_ALT);

  assign o_rdidx   = ir.r.rd;
  assign o_csr_idx = ir.i.imm12;
  assign o_imm     = {{(`EXU_XLEN-`EXU_CSR_IDX_W){ir.i.imm12[`EXU_CSR_IDX_W-1]}}, ir.i.imm12};

  always_comb begin
    case (ir.r.funct3)
      `EXU_F3_ADD:  base_op = exu_pkg::ALU_ADD;
      `EXU_F3_SLL:  base_op = exu_pkg::ALU_SLL;
      `EXU_F3_SLT:  base_op = exu_pkg::ALU_SLT;
      `EXU_F3_SLTU: base_op = exu_pkg::ALU_SLTU;
      `EXU_F3_XOR:  base_op = exu_pkg::ALU_XOR;
      `EXU_F3_SR:   base_op = hi_alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
      `EXU_F3_OR:   base_op = exu_pkg::ALU_OR;
      default:      base_op = exu_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    o_rs1idx  = ir.r.rs1;
    o_rs2idx  = ir.r.rs2;
    o_rdwen   = 1'b0;
    o_use_imm = 1'b0;
    o_alu_op  = base_op;
    o_csr_op  = exu_pkg::CSR_NONE;
    o_ilegl   = 1'b0;
    case (ir.r.opcode)
      `EXU_OPC_OP: begin
        o_rdwen = 1'b1;
        if (ir.r.funct3 == `EXU_F3_ADD && hi_alt) o_alu_op = exu_pkg::ALU_SUB;
        // Only ADD and SR accept the alternate funct7
        o_ilegl = !(hi_base ||
                    (hi_alt && (ir.r.funct3 == `EXU_F3_ADD || ir.r.funct3 == `EXU_F3_SR)));
      end
      `EXU_OPC_OPIMM: begin
        o_rdwen   = 1'b1;
        o_use_imm = 1'b1;
        if (ir.i.funct3 == `EXU_F3_SLL) o_ilegl = !hi_base;
        if (ir.i.funct3 == `EXU_F3_SR)  o_ilegl = !(hi_base || hi_alt);
      end
      `EXU_OPC_SYSTEM: begin
        o_rdwen  = 1'b1;
        case (ir.i.funct3)
          `EXU_F3_CSRRW: o_csr_op = exu_pkg::CSR_WRITE;
          `EXU_F3_CSRRS: o_csr_op = exu_pkg::CSR_SET;
          default:       o_ilegl  = 1'b1;  // ECALL, EBREAK and the rest
        endcase
      end
      default: o_ilegl = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/exu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the execute unit
// Instruction views, data words and the ALU and CSR operation codes
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exu_consts.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0]    word_t;
  typedef logic [`EXU_RFIDX_W-1:0] rfidx_t;

  // Register-register format
  typedef struct packed {
    logic [6:0] funct7;
    rfidx_t     rs2;
    rfidx_t     rs1;
    logic [2:0] funct3;
    rfidx_t     rd;
    logic [6:0] opcode;
  } rtype_s;

  // Immediate format, imm12 is also the CSR address
  typedef struct packed {
    logic [`EXU_CSR_IDX_W-1:0] imm12;
    rfidx_t                    rs1;
    logic [2:0]                funct3;
    rfidx_t                    rd;
    logic [6:0]                opcode;
  } itype_s;

  typedef union packed {
    rtype_s r;
    itype_s i;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_NONE, CSR_WRITE, CSR_SET
  } csr_op_e;

endpackage

`default_nettype wire

// ==== verilog/exu_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// Width, opcode, funct and CSR address constants for the execute unit
// Included by the package and by any module that decodes or sizes fields
////////////////////////////////////////////////////////////////////////////

`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

`define EXU_XLEN        32
`define EXU_RFIDX_W     5
`define EXU_INSTR_W     32
`define EXU_CSR_IDX_W   12

// Major opcodes
`define EXU_OPC_OP      7'b0110011
`define EXU_OPC_OPIMM   7'b0010011
`define EXU_OPC_SYSTEM  7'b1110011

// ALU funct3 codes
`define EXU_F3_ADD      3'b000
`define EXU_F3_SLL      3'b001
`define EXU_F3_SLT      3'b010
`define EXU_F3_SLTU     3'b011
`define EXU_F3_XOR      3'b100
`define EXU_F3_SR       3'b101
`define EXU_F3_OR       3'b110
`define EXU_F3_AND      3'b111

`define EXU_F7_BASE     7'b0000000
`define EXU_F7_ALT      7'b0100000  // SUB and SRA

// CSR funct3 codes
`define EXU_F3_CSRRW    3'b001
`define EXU_F3_CSRRS    3'b010

// Machine CSR addresses
`define EXU_CSR_MSCRATCH  12'h340
`define EXU_CSR_MEPC      12'h341
`define EXU_CSR_MCAUSE    12'h342
`define EXU_CSR_MINSTRET  12'hB02

`define EXU_CAUSE_ILLEGAL 32'd2

`endif
